/* mem_sys.f */
mem_sys_pkg.sv
axi_lite_if.sv
axi_arbiter.sv
axi_sram.sv
mem_sys_top.sv
tb_clk_gen.sv
tb_mem_sys.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tb_mem_sys
FILELIST  ?= mem_sys.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf $(OBJDIR)

/* tb_mem_sys.sv */
/*
 * random stimulus against a word model of the SRAM with seed 51
 * inputs change on the rising edge and outputs are sampled on the falling edge
 * every wait gives up after TIMEOUT cycles
 */
module tb_mem_sys;
	timeunit 1ns;
	timeprecision 100ps;
	import mem_sys_pkg::*;

	localparam int ADDR_W    = 32;
	localparam int DATA_W    = 32;
	localparam int MEM_DEPTH = 256;
	localparam int TIMEOUT   = 200;

	logic clk;
	logic rst;
	logic [ADDR_W-1:0] inst_araddr_i, data_araddr_i, data_awaddr_i;
	logic              inst_arvalid_i, inst_rready_i, data_arvalid_i, data_rready_i;
	logic              data_awvalid_i, data_wvalid_i, data_bready_i;
	logic [DATA_W-1:0] data_wdata_i;
	logic [3:0]        data_wstrb_i;
	logic              inst_arready_o, inst_rvalid_o, data_arready_o, data_rvalid_o;
	logic              data_awready_o, data_wready_o, data_bvalid_o;
	logic [DATA_W-1:0] inst_rdata_o, data_rdata_o;
	axi_resp_e         inst_rresp_o, data_rresp_o, data_bresp_o;

	logic [DATA_W-1:0] model_mem [MEM_DEPTH]; // expected SRAM contents
	int errors;
	int test_errors;
	int tests_run;
	int tests_failed;

	tb_clk_gen #(.RST_CYCLES(16)) u_clk_gen (.clk_o(clk), .rst_o(rst));

	mem_sys_top #(
		.ADDR_W(ADDR_W),
		.DATA_W(DATA_W),
		.MEM_DEPTH(MEM_DEPTH)
	) dut (
		.clk_i(clk),
		.rst_i(rst),
		.*
	);

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
		assert (got === exp) else begin
			$display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic abort_on_timeout(input string chan);
		$display("timeout: gave up waiting for %s after %0d cycles", chan, TIMEOUT);
		$display("FAIL: see errors above");
		$finish;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors != test_errors) tests_failed++;
		$display("test %0d %s: %s", tests_run, name, (errors == test_errors) ? "ok" : "failed");
		test_errors = errors;
	endtask

	// in range when the word index is below MEM_DEPTH
	function automatic bit in_range(input logic [31:0] addr);
		return (addr >> 2) < MEM_DEPTH;
	endfunction

	function automatic logic [31:0] apply_strobe(input logic [31:0] old, input logic [31:0] wd,
		input logic [3:0] strb);
		logic [31:0] res;
		res = old;
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) res[b*8 +: 8] = wd[b*8 +: 8];
		end
		return res;
	endfunction

	// called on a rising edge with the request already driven
	task automatic wait_data_ar();
		int n;
		n = 0;
		do begin
			@(negedge clk);
			check_val("inst_arready_o", 32'd0, 32'(inst_arready_o)); // data wins
			n++;
			if (n > TIMEOUT) abort_on_timeout("data AR");
		end while (!data_arready_o);
		@(posedge clk);
		data_arvalid_i <= 1'b0;
	endtask

	task automatic wait_inst_ar();
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT) abort_on_timeout("instruction AR");
		end while (!inst_arready_o);
		@(posedge clk);
		inst_arvalid_i <= 1'b0;
	endtask

	// response with rready held low for hold cycles after rvalid
	task automatic wait_data_r(input int hold, output logic [31:0] rd, output logic [1:0] rsp);
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT) abort_on_timeout("data R");
		end while (!data_rvalid_o);
		rd = data_rdata_o;
		rsp = data_rresp_o;
		repeat (hold) begin
			@(negedge clk);
			check_val("data_rvalid_o", 32'd1, 32'(data_rvalid_o));
			check_val("data_rdata_o", rd, data_rdata_o);
			check_val("inst_arready_o", 32'd0, 32'(inst_arready_o)); // no grant while held
		end
		@(posedge clk);
		data_rready_i <= 1'b1;
		@(posedge clk);
		data_rready_i <= 1'b0;
	endtask

	task automatic wait_inst_r(output logic [31:0] rd, output logic [1:0] rsp);
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT) abort_on_timeout("instruction R");
		end while (!inst_rvalid_o);
		rd = inst_rdata_o;
		rsp = inst_rresp_o;
		@(posedge clk);
		inst_rready_i <= 1'b1;
		@(posedge clk);
		inst_rready_i <= 1'b0;
	endtask

	task automatic data_write(input logic [31:0] addr, input logic [31:0] wd,
		input logic [3:0] strb, input int hold);
		int n;
		logic [1:0] rsp;
		logic [1:0] exp_rsp;
		@(posedge clk);
		data_awaddr_i  <= addr;
		data_wdata_i   <= wd;
		data_wstrb_i   <= strb;
		data_awvalid_i <= 1'b1;
		data_wvalid_i  <= 1'b1;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT) abort_on_timeout("data AW/W");
		end while (!data_awready_o);
		check_val("data_wready_o", 32'd1, 32'(data_wready_o));
		@(posedge clk);
		data_awvalid_i <= 1'b0;
		data_wvalid_i  <= 1'b0;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT) abort_on_timeout("data B");
		end while (!data_bvalid_o);
		rsp = data_bresp_o;
		repeat (hold) begin
			@(negedge clk);
			check_val("data_bvalid_o", 32'd1, 32'(data_bvalid_o));
			check_val("data_bresp_o", 32'(rsp), 32'(data_bresp_o));
		end
		@(posedge clk);
		data_bready_i <= 1'b1;
		@(posedge clk);
		data_bready_i <= 1'b0;
		exp_rsp = in_range(addr) ? 2'b00 : 2'b10;
		check_val("data_bresp_o", 32'(exp_rsp), 32'(rsp));
		if (in_range(addr)) model_mem[addr >> 2] = apply_strobe(model_mem[addr >> 2], wd, strb);
	endtask

	task automatic data_read(input logic [31:0] addr, input int hold);
		logic [31:0] rd;
		logic [1:0]  rsp;
		@(posedge clk);
		data_araddr_i  <= addr;
		data_arvalid_i <= 1'b1;
		wait_data_ar();
		wait_data_r(hold, rd, rsp);
		check_val("data_rdata_o", in_range(addr) ? model_mem[addr >> 2] : 32'd0, rd);
		check_val("data_rresp_o", in_range(addr) ? 32'd0 : 32'd2, 32'(rsp));
	endtask

	task automatic inst_read(input logic [31:0] addr);
		logic [31:0] rd;
		logic [1:0]  rsp;
		@(posedge clk);
		inst_araddr_i  <= addr;
		inst_arvalid_i <= 1'b1;
		wait_inst_ar();
		wait_inst_r(rd, rsp);
		check_val("inst_rdata_o", in_range(addr) ? model_mem[addr >> 2] : 32'd0, rd);
		check_val("inst_rresp_o", in_range(addr) ? 32'd0 : 32'd2, 32'(rsp));
	endtask

	initial begin
		logic [31:0] addr;
		logic [31:0] addr2;
		logic [31:0] rd;
		logic [1:0]  rsp;
		int          n;
		void'($urandom(51));
		errors = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		for (int i = 0; i < MEM_DEPTH; i++) model_mem[i] = '0;
		inst_araddr_i  = '0;
		inst_arvalid_i = 1'b0;
		inst_rready_i  = 1'b0;
		data_araddr_i  = '0;
		data_arvalid_i = 1'b0;
		data_rready_i  = 1'b0;
		data_awaddr_i  = '0;
		data_awvalid_i = 1'b0;
		data_wdata_i   = '0;
		data_wstrb_i   = '0;
		data_wvalid_i  = 1'b0;
		data_bready_i  = 1'b0;

		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT) abort_on_timeout("reset release");
		end while (rst);
		check_val("inst_arready_o", 32'd0, 32'(inst_arready_o));
		check_val("data_arready_o", 32'd0, 32'(data_arready_o));
		check_val("data_awready_o", 32'd0, 32'(data_awready_o));
		check_val("data_wready_o", 32'd0, 32'(data_wready_o));
		check_val("inst_rvalid_o", 32'd0, 32'(inst_rvalid_o));
		check_val("data_rvalid_o", 32'd0, 32'(data_rvalid_o));
		check_val("data_bvalid_o", 32'd0, 32'(data_bvalid_o));
		finish_test("reset state");

		for (int i = 0; i < 40; i++) begin
			addr = 32'($urandom_range(0, MEM_DEPTH - 1)) << 2;
			if (i % 2 == 0) data_write(addr, $urandom(), 4'hf, 0);
			else data_write(addr, $urandom(), 4'($urandom_range(1, 15)), 0);
			data_read(addr, 0);
		end
		finish_test("data write then read");

		for (int i = 0; i < 30; i++) begin
			inst_read(32'($urandom_range(0, MEM_DEPTH - 1)) << 2);
		end
		finish_test("instruction reads");

		for (int i = 0; i < 10; i++) begin
			addr  = 32'($urandom_range(0, MEM_DEPTH - 1)) << 2;
			addr2 = 32'($urandom_range(0, MEM_DEPTH - 1)) << 2;
			@(posedge clk);
			data_araddr_i  <= addr;
			data_arvalid_i <= 1'b1;
			inst_araddr_i  <= addr2;
			inst_arvalid_i <= 1'b1; // same edge as the data request
			wait_data_ar();
			wait_data_r(0, rd, rsp);
			check_val("data_rdata_o", model_mem[addr >> 2], rd);
			check_val("data_rresp_o", 32'd0, 32'(rsp));
			wait_inst_ar();
			wait_inst_r(rd, rsp);
			check_val("inst_rdata_o", model_mem[addr2 >> 2], rd);
			check_val("inst_rresp_o", 32'd0, 32'(rsp));
		end
		finish_test("data over instruction priority");

		for (int i = 0; i < 10; i++) begin
			addr = 32'($urandom_range(MEM_DEPTH, 4 * MEM_DEPTH)) << 2;
			data_write(addr, $urandom(), 4'hf, 0);
			data_read(addr, 0);
			inst_read(addr);
			data_read(addr % (4 * MEM_DEPTH), 0); // word the truncated index would hit
		end
		finish_test("out of range SLVERR");

		for (int i = 0; i < 10; i++) begin
			addr = 32'($urandom_range(0, MEM_DEPTH - 1)) << 2;
			data_write(addr, $urandom(), 4'hf, $urandom_range(1, 8));
			@(posedge clk);
			data_araddr_i  <= addr;
			data_arvalid_i <= 1'b1;
			inst_araddr_i  <= addr;
			inst_arvalid_i <= 1'b1; // pending fetch must wait for the held response
			wait_data_ar();
			wait_data_r($urandom_range(1, 8), rd, rsp);
			check_val("data_rdata_o", model_mem[addr >> 2], rd);
			wait_inst_ar();
			wait_inst_r(rd, rsp);
			check_val("inst_rdata_o", model_mem[addr >> 2], rd);
		end
		finish_test("response back-pressure");

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

/* tb_clk_gen.sv */
/*
 * clock and reset source for the memory subsystem testbench
 * 8 ns period, reset high for RST_CYCLES rising edges
 */
module tb_clk_gen #(
	parameter int RST_CYCLES = 16
) (
	output logic clk_o,
	output logic rst_o
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk_o = 1'b0;
		forever #4 clk_o = ~clk_o;
	end

	initial begin
		rst_o = 1'b1;
		repeat (RST_CYCLES) @(posedge clk_o);
		rst_o <= 1'b0; // released on an edge like any other input
	end

endmodule

/* mem_sys_top.sv */
/*
 * memory subsystem top, fetch and data ports sharing one SRAM
 * ADDR_W, DATA_W and MEM_DEPTH are passed down unchanged
 */
module mem_sys_top #(
	parameter int ADDR_W    = 32,
	parameter int DATA_W    = 32,
	parameter int MEM_DEPTH = 256
) (
	input  logic                   clk_i,
	input  logic                   rst_i,

	// instruction fetch
	input  logic [ADDR_W-1:0]      inst_araddr_i,
	input  logic                   inst_arvalid_i,
	output logic                   inst_arready_o,
	output logic [DATA_W-1:0]      inst_rdata_o,
	output mem_sys_pkg::axi_resp_e inst_rresp_o,
	output logic                   inst_rvalid_o,
	input  logic                   inst_rready_i,

	// data load and store
	input  logic [ADDR_W-1:0]      data_araddr_i,
	input  logic                   data_arvalid_i,
	output logic                   data_arready_o,
	output logic [DATA_W-1:0]      data_rdata_o,
	output mem_sys_pkg::axi_resp_e data_rresp_o,
	output logic                   data_rvalid_o,
	input  logic                   data_rready_i,
	input  logic [ADDR_W-1:0]      data_awaddr_i,
	input  logic                   data_awvalid_i,
	output logic                   data_awready_o,
	input  logic [DATA_W-1:0]      data_wdata_i,
	input  logic [DATA_W/mem_sys_pkg::STRB_PER_BYTE-1:0] data_wstrb_i,
	input  logic                   data_wvalid_i,
	output logic                   data_wready_o,
	output mem_sys_pkg::axi_resp_e data_bresp_o,
	output logic                   data_bvalid_o,
	input  logic                   data_bready_i
);

	axi_lite_if #(
		.ADDR_W(ADDR_W),
		.DATA_W(DATA_W)
	) mem_bus ();

	// requester ports share names with the top
	axi_arbiter #(
		.ADDR_W(ADDR_W),
		.DATA_W(DATA_W)
	) u_arbiter (
		.mem(mem_bus.master),
		.*
	);

	axi_sram #(
		.ADDR_W(ADDR_W),
		.DATA_W(DATA_W),
		.MEM_DEPTH(MEM_DEPTH)
	) u_sram (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.s(mem_bus.slave)
	);

endmodule

/* axi_sram.sv */
/*
 * word addressed SRAM behind AXI-Lite, one transaction at a time
 * rvalid 2 cycles after AR, bvalid 1 cycle after the later of AW and W
 * addresses at or beyond MEM_DEPTH words give SLVERR, memory clears on reset
 */
module axi_sram #(
	parameter int ADDR_W    = 32,
	parameter int DATA_W    = 32,
	parameter int MEM_DEPTH = 256
) (
	input  logic      clk_i,
	input  logic      rst_i,
	axi_lite_if.slave s
);
	import mem_sys_pkg::*;

	localparam int STRB_W = DATA_W / STRB_PER_BYTE;
	localparam int OFF_W  = $clog2(STRB_W);    // byte offset bits
	localparam int IDX_W  = $clog2(MEM_DEPTH);
	localparam int WORD_W = ADDR_W - OFF_W;

	logic [DATA_W-1:0] mem_q [MEM_DEPTH];

	logic              up_q;     // out of reset
	logic [1:0]        rd_cnt_q; // read latency
	logic              aw_got_q;
	logic              w_got_q;
	logic              rvalid_q;
	logic              bvalid_q;
	logic [ADDR_W-1:0] raddr_q;
	logic [ADDR_W-1:0] waddr_q;
	logic [DATA_W-1:0] wdata_q;
	logic [STRB_W-1:0] wstrb_q;
	logic [DATA_W-1:0] rdata_q;
	axi_resp_e         rresp_q;
	axi_resp_e         bresp_q;

	logic              idle;
	logic              wr_go;    // both write halves present
	logic [WORD_W-1:0] rword;
	logic [WORD_W-1:0] wword;
	logic              rd_in;
	logic              wr_in;

	assign rword = raddr_q[ADDR_W-1:OFF_W];
	assign wword = waddr_q[ADDR_W-1:OFF_W];
	assign rd_in = rword < MEM_DEPTH;
	assign wr_in = wword < MEM_DEPTH;

	assign wr_go = aw_got_q && w_got_q;
	assign idle  = up_q && !rvalid_q && !bvalid_q && rd_cnt_q == 2'd0 && !wr_go;

	// reads wait while any write half is around
	assign s.arready = idle && !aw_got_q && !w_got_q && !s.awvalid && !s.wvalid;
	assign s.awready = idle && !aw_got_q;
	assign s.wready  = idle && !w_got_q;

	assign s.rdata  = rdata_q;
	assign s.rresp  = rresp_q;
	assign s.rvalid = rvalid_q;
	assign s.bresp  = bresp_q;
	assign s.bvalid = bvalid_q;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			up_q     <= 1'b0;
			rd_cnt_q <= 2'd0;
			aw_got_q <= 1'b0;
			w_got_q  <= 1'b0;
			rvalid_q <= 1'b0;
			bvalid_q <= 1'b0;
			for (int i = 0; i < MEM_DEPTH; i++) begin
				mem_q[i] <= '0;
			end
		end else begin
			up_q <= 1'b1;

			if (s.arvalid && s.arready) begin
				rd_cnt_q <= 2'd2;
			end else if (rd_cnt_q != 2'd0) begin
				rd_cnt_q <= rd_cnt_q - 2'd1;
			end
			if (rd_cnt_q == 2'd1) begin
				rvalid_q <= 1'b1;
			end else if (s.rready) begin
				rvalid_q <= 1'b0;
			end

			if (s.awvalid && s.awready) aw_got_q <= 1'b1;
			if (s.wvalid && s.wready) w_got_q <= 1'b1;

			if (wr_go) begin
				aw_got_q <= 1'b0;
				w_got_q  <= 1'b0;
				bvalid_q <= 1'b1;
				if (wr_in) begin
					for (int b = 0; b < STRB_W; b++) begin
						if (wstrb_q[b]) begin
							mem_q[wword[IDX_W-1:0]][b*STRB_PER_BYTE +: STRB_PER_BYTE] <=
								wdata_q[b*STRB_PER_BYTE +: STRB_PER_BYTE];
						end
					end
				end
			end else if (s.bready) begin
				bvalid_q <= 1'b0;
			end
		end
	end

	// captured request fields and response payload
	always_ff @(posedge clk_i) begin
		if (s.arvalid && s.arready) raddr_q <= s.araddr;
		if (s.awvalid && s.awready) waddr_q <= s.awaddr;
		if (s.wvalid && s.wready) begin
			wdata_q <= s.wdata;
			wstrb_q <= s.wstrb;
		end
		if (rd_cnt_q == 2'd1) begin
			rdata_q <= rd_in ? mem_q[rword[IDX_W-1:0]] : '0; // zero on a miss
			rresp_q <= rd_in ? OKAY : SLVERR;
		end
		if (wr_go) bresp_q <= wr_in ? OKAY : SLVERR;
	end

endmodule

/* axi_arbiter.sv */
/*
 * one transaction in flight, data has priority over instruction fetch
 * a data write is granted only with AW and W valid together
 * responses are registered and held until the owner takes them
 */
module axi_arbiter #(
	parameter int ADDR_W = 32,
	parameter int DATA_W = 32
) (
	input  logic                   clk_i,
	input  logic                   rst_i,

	// instruction fetch, read only
	input  logic [ADDR_W-1:0]      inst_araddr_i,
	input  logic                   inst_arvalid_i,
	output logic                   inst_arready_o,
	output logic [DATA_W-1:0]      inst_rdata_o,
	output mem_sys_pkg::axi_resp_e inst_rresp_o,
	output logic                   inst_rvalid_o,
	input  logic                   inst_rready_i,

	// data read
	input  logic [ADDR_W-1:0]      data_araddr_i,
	input  logic                   data_arvalid_i,
	output logic                   data_arready_o,
	output logic [DATA_W-1:0]      data_rdata_o,
	output mem_sys_pkg::axi_resp_e data_rresp_o,
	output logic                   data_rvalid_o,
	input  logic                   data_rready_i,

	// data write
	input  logic [ADDR_W-1:0]      data_awaddr_i,
	input  logic                   data_awvalid_i,
	output logic                   data_awready_o,
	input  logic [DATA_W-1:0]      data_wdata_i,
	input  logic [DATA_W/mem_sys_pkg::STRB_PER_BYTE-1:0] data_wstrb_i,
	input  logic                   data_wvalid_i,
	output logic                   data_wready_o,
	output mem_sys_pkg::axi_resp_e data_bresp_o,
	output logic                   data_bvalid_o,
	input  logic                   data_bready_i,

	axi_lite_if.master             mem
);
	import mem_sys_pkg::*;

	localparam int STRB_W = DATA_W / STRB_PER_BYTE;

	arb_state_e        state_q;
	arb_state_e        state_d;
	logic              grant_wr;
	logic              grant_drd;
	logic              grant_ird;
	logic              rsp_done;   // owner took its response

	logic              is_wr_q;    // granted transaction is a write
	logic              rsp_wait_q; // SRAM response still outstanding
	logic              arvalid_q;
	logic              awvalid_q;
	logic              wvalid_q;
	logic [ADDR_W-1:0] addr_q;     // shared by AR and AW
	logic [DATA_W-1:0] wdata_q;
	logic [STRB_W-1:0] wstrb_q;

	logic              inst_rvalid_q;
	logic              data_rvalid_q;
	logic              data_bvalid_q;
	logic [DATA_W-1:0] inst_rdata_q;
	logic [DATA_W-1:0] data_rdata_q;
	axi_resp_e         inst_rresp_q;
	axi_resp_e         data_rresp_q;
	axi_resp_e         data_bresp_q;

	// fixed priority: write, data read, fetch
	always_comb begin
		grant_wr  = 1'b0;
		grant_drd = 1'b0;
		grant_ird = 1'b0;
		if (state_q == ARB_IDLE) begin
			if (data_awvalid_i && data_wvalid_i) begin
				grant_wr = 1'b1;
			end else if (data_arvalid_i) begin
				grant_drd = 1'b1;
			end else if (inst_arvalid_i) begin
				grant_ird = 1'b1;
			end
		end
	end

	assign rsp_done = (inst_rvalid_q && inst_rready_i) ||
		(data_rvalid_q && data_rready_i) ||
		(data_bvalid_q && data_bready_i);

	always_comb begin
		state_d = state_q;
		case (state_q)
			ARB_IDLE: begin
				if (grant_wr || grant_drd) begin
					state_d = ARB_DATA;
				end else if (grant_ird) begin
					state_d = ARB_INST;
				end
			end
			ARB_DATA, ARB_INST: begin
				if (rsp_done) begin
					state_d = ARB_IDLE;
				end
			end
			default: state_d = ARB_IDLE;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q       <= ARB_IDLE;
			is_wr_q       <= 1'b0;
			rsp_wait_q    <= 1'b0;
			arvalid_q     <= 1'b0;
			awvalid_q     <= 1'b0;
			wvalid_q      <= 1'b0;
			inst_rvalid_q <= 1'b0;
			data_rvalid_q <= 1'b0;
			data_bvalid_q <= 1'b0;
		end else begin
			state_q <= state_d;
			if (grant_wr || grant_drd || grant_ird) begin
				is_wr_q    <= grant_wr;
				rsp_wait_q <= 1'b1;
			end

			// request valids rise the cycle after the grant
			if (grant_drd || grant_ird) begin
				arvalid_q <= 1'b1;
			end else if (mem.arready) begin
				arvalid_q <= 1'b0;
			end
			if (grant_wr) begin
				awvalid_q <= 1'b1;
				wvalid_q  <= 1'b1;
			end else begin
				if (mem.awready) awvalid_q <= 1'b0; // halves may go separately
				if (mem.wready) wvalid_q <= 1'b0;
			end

			if (mem.rvalid && mem.rready) begin
				rsp_wait_q <= 1'b0;
				if (state_q == ARB_INST) begin
					inst_rvalid_q <= 1'b1;
				end else begin
					data_rvalid_q <= 1'b1;
				end
			end
			if (mem.bvalid && mem.bready) begin
				rsp_wait_q    <= 1'b0;
				data_bvalid_q <= 1'b1;
			end

			if (inst_rvalid_q && inst_rready_i) inst_rvalid_q <= 1'b0;
			if (data_rvalid_q && data_rready_i) data_rvalid_q <= 1'b0;
			if (data_bvalid_q && data_bready_i) data_bvalid_q <= 1'b0;
		end
	end

	// request and response payload
	always_ff @(posedge clk_i) begin
		if (grant_wr) begin
			addr_q  <= data_awaddr_i;
			wdata_q <= data_wdata_i;
			wstrb_q <= data_wstrb_i;
		end else if (grant_drd) begin
			addr_q <= data_araddr_i;
		end else if (grant_ird) begin
			addr_q <= inst_araddr_i;
		end

		if (mem.rvalid && mem.rready) begin
			if (state_q == ARB_INST) begin
				inst_rdata_q <= mem.rdata;
				inst_rresp_q <= mem.rresp;
			end else begin
				data_rdata_q <= mem.rdata;
				data_rresp_q <= mem.rresp;
			end
		end
		if (mem.bvalid && mem.bready) data_bresp_q <= mem.bresp;
	end

	// requester side
	assign inst_arready_o = grant_ird;
	assign data_arready_o = grant_drd;
	assign data_awready_o = grant_wr;
	assign data_wready_o  = grant_wr;

	assign inst_rdata_o  = inst_rdata_q;
	assign inst_rresp_o  = inst_rresp_q;
	assign inst_rvalid_o = inst_rvalid_q;
	assign data_rdata_o  = data_rdata_q;
	assign data_rresp_o  = data_rresp_q;
	assign data_rvalid_o = data_rvalid_q;
	assign data_bresp_o  = data_bresp_q;
	assign data_bvalid_o = data_bvalid_q;

	// SRAM side
	assign mem.araddr  = addr_q;
	assign mem.arvalid = arvalid_q;
	assign mem.awaddr  = addr_q;
	assign mem.awvalid = awvalid_q;
	assign mem.wdata   = wdata_q;
	assign mem.wstrb   = wstrb_q;
	assign mem.wvalid  = wvalid_q;
	assign mem.rready  = rsp_wait_q && !is_wr_q;
	assign mem.bready  = rsp_wait_q && is_wr_q;

endmodule

/* axi_lite_if.sv */
/*
 * AXI-Lite bundle of the five channels, no prot or cache signals
 * strobe width is DATA_W / STRB_PER_BYTE
 */
interface axi_lite_if #(
	parameter int ADDR_W = 32,
	parameter int DATA_W = 32
);
	import mem_sys_pkg::*;

	localparam int STRB_W = DATA_W / STRB_PER_BYTE;

	// read address
	logic [ADDR_W-1:0] araddr;
	logic              arvalid;
	logic              arready;

	// read data
	logic [DATA_W-1:0] rdata;
	axi_resp_e         rresp;
	logic              rvalid;
	logic              rready;

	// write address
	logic [ADDR_W-1:0] awaddr;
	logic              awvalid;
	logic              awready;

	// write data
	logic [DATA_W-1:0] wdata;
	logic [STRB_W-1:0] wstrb;
	logic              wvalid;
	logic              wready;

	// write response
	axi_resp_e         bresp;
	logic              bvalid;
	logic              bready;

	modport master (
		output araddr, arvalid, input arready,
		input rdata, rresp, rvalid, output rready,
		output awaddr, awvalid, input awready,
		output wdata, wstrb, wvalid, input wready,
		input bresp, bvalid, output bready
	);

	modport slave (
		input araddr, arvalid, output arready,
		output rdata, rresp, rvalid, input rready,
		input awaddr, awvalid, output awready,
		input wdata, wstrb, wvalid, output wready,
		output bresp, bvalid, input bready
	);

endinterface

/* mem_sys_pkg.sv */
/*
 * shared types for the memory subsystem
 * response codes follow AXI encoding, only OKAY and SLVERR are produced
 */
package mem_sys_pkg;

	// fixed widths of the bus side fields
	localparam int RESP_W = 2;
	localparam int STATE_W = 2;

	// data bits covered by one strobe bit
	localparam int STRB_PER_BYTE = 8;

	// read and write response codes
	typedef enum logic [RESP_W-1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10 // address beyond the memory
	} axi_resp_e;

	// arbiter controller states
	typedef enum logic [STATE_W-1:0] {
		ARB_IDLE = 2'b00, // free to grant
		ARB_DATA = 2'b01, // data read or write owns the bus
		ARB_INST = 2'b10  // instruction fetch owns the bus
	} arb_state_e;

endpackage
